// ==== common/mcpu_dport_if.sv ====
`timescale 1ns/1ns

interface mcpu_dport_if;

  logic                          valid;  // Level, held until ready
  logic [mcpu_pkg::paddr_w-1:0]  paddr;
  logic [mcpu_pkg::be_w-1:0]     write;  // Zero means read
  logic [mcpu_pkg::data_w-1:0]   wdata;
  logic [mcpu_pkg::data_w-1:0]   rdata;

  modport core (
    output valid,
    output paddr,
    output write,
    output wdata,
    input  rdata
  );

  modport mem (
    input  valid,
    input  paddr,
    input  write,
    input  wdata,
    output rdata
  );

endinterface

// ==== common/mcpu_periph_if.sv ====
`timescale 1ns/1ns

interface mcpu_periph_if;

  logic                                re;     // Single-cycle read strobe
  logic [mcpu_pkg::be_w-1:0]           we;     // Byte write strobes
  logic [mcpu_pkg::mmio_aw-1:0]        addr;   // Word offset in MMIO space
  logic [mcpu_pkg::data_w-1:0]         wdata;
  logic [mcpu_pkg::data_w-1:0]         rdata;  // Comb from addr

  modport master (
    output re,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport slave (
    input  re,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// ==== common/mcpu_pkg.sv ====
package mcpu_pkg;

  // Core data port geometry
  localparam int paddr_w = 30;         // Word address, byte offset dropped
  localparam int data_w  = 32;
  localparam int be_w    = 4;          // One enable per byte lane

  // On-chip data RAM
  localparam int dmem_words = 256;
  localparam int dmem_aw    = 8;       // log2 of dmem_words

  // Upper half of the word space goes to MMIO
  localparam int periph_bit = 29;

  // Peripheral word offsets
  localparam int mmio_aw          = 2;
  localparam int mmio_memoutput   = 0; // RW, byte writable
  localparam int mmio_meminput    = 1; // RO, pin sample
  localparam int mmio_uart_data   = 2; // WO, kicks a frame
  localparam int mmio_uart_status = 3; // RO, read clears overrun

  // UART transmitter
  localparam int uart_div        = 16; // Clocks per bit
  localparam int uart_frame_bits = 10; // Start + 8 data + stop
  localparam int uart_status_w   = 2;  // {overrun, busy}

endpackage

// ==== design/mcpu_soc_top.sv ====
`timescale 1ns/1ns

module mcpu_soc_top (
  input  logic                               clkrst_core_clk,
  input  logic                               arst_n,
  input  logic                               mem2dc_valid0,
  input  logic [mcpu_pkg::paddr_w-1:0]       mem2dc_paddr0,
  input  logic [mcpu_pkg::be_w-1:0]          mem2dc_write0,
  input  logic [mcpu_pkg::data_w-1:0]        mem2dc_data_out0,
  output logic [mcpu_pkg::data_w-1:0]        mem2dc_data_in0,
  input  logic                               mem2dc_valid1,
  input  logic [mcpu_pkg::paddr_w-1:0]       mem2dc_paddr1,
  input  logic [mcpu_pkg::be_w-1:0]          mem2dc_write1,
  input  logic [mcpu_pkg::data_w-1:0]        mem2dc_data_out1,
  output logic [mcpu_pkg::data_w-1:0]        mem2dc_data_in1,
  output logic                               dl1c_ready,     // Shared done, both ports
  output logic                               pre2core_done,  // Core release
  input  logic [mcpu_pkg::data_w-1:0]        meminput,
  output logic [mcpu_pkg::data_w-1:0]        memoutput,
  output logic                               uart_tx,
  output logic [mcpu_pkg::uart_status_w-1:0] uart_status
);

  logic                        arb_req0;
  logic                        arb_req1;
  logic                        arb_done0;
  logic                        arb_done1;
  logic [mcpu_pkg::data_w-1:0] arb_rdata;

  mcpu_dport_if  dport0_if ();
  mcpu_dport_if  dport1_if ();
  mcpu_periph_if periph_if ();

  // Core side of the data ports
  assign dport0_if.valid = mem2dc_valid0;
  assign dport0_if.paddr = mem2dc_paddr0;
  assign dport0_if.write = mem2dc_write0;
  assign dport0_if.wdata = mem2dc_data_out0;
  assign mem2dc_data_in0 = dport0_if.rdata;

  assign dport1_if.valid = mem2dc_valid1;
  assign dport1_if.paddr = mem2dc_paddr1;
  assign dport1_if.write = mem2dc_write1;
  assign dport1_if.wdata = mem2dc_data_out1;
  assign mem2dc_data_in1 = dport1_if.rdata;

  mcpu_mem u_mem (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .dport0          (dport0_if.mem),
    .dport1          (dport1_if.mem),
    .pre2core_done   (pre2core_done),
    .dl1c_ready      (dl1c_ready),
    .arb_req0        (arb_req0),
    .arb_req1        (arb_req1),
    .arb_done0       (arb_done0),
    .arb_done1       (arb_done1),
    .arb_rdata       (arb_rdata)
  );

  mcpu_periph_arb u_arb (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .req0            (arb_req0),
    .req1            (arb_req1),
    .dport0          (dport0_if.mem),
    .dport1          (dport1_if.mem),
    .bus             (periph_if.master),
    .done0           (arb_done0),
    .done1           (arb_done1),
    .rdata           (arb_rdata)
  );

  mcpu_soc_mmio u_mmio (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bus             (periph_if.slave),
    .meminput        (meminput),
    .memoutput       (memoutput),
    .uart_tx         (uart_tx),
    .uart_status     (uart_status)
  );

endmodule

// ==== mem/mcpu_mem.sv ====
`timescale 1ns/1ns

module mcpu_mem (
  input  logic                        clkrst_core_clk,
  input  logic                        arst_n,
  mcpu_dport_if.mem                   dport0,
  mcpu_dport_if.mem                   dport1,
  output logic                        pre2core_done,
  output logic                        dl1c_ready,
  output logic                        arb_req0,
  output logic                        arb_req1,
  input  logic                        arb_done0,
  input  logic                        arb_done1,
  input  logic [mcpu_pkg::data_w-1:0] arb_rdata
);

  logic [mcpu_pkg::data_w-1:0]  ram [mcpu_pkg::dmem_words];
  logic [mcpu_pkg::dmem_aw-1:0] init_idx;       // Zero-fill sweep pointer
  logic [mcpu_pkg::dmem_aw-1:0] idx0;
  logic [mcpu_pkg::dmem_aw-1:0] idx1;
  logic [mcpu_pkg::data_w-1:0]  rdata0_q;
  logic [mcpu_pkg::data_w-1:0]  rdata1_q;
  logic                         active;         // Set has MMIO work left
  logic                         wait0;
  logic                         wait1;
  logic                         acc;            // New request set taken
  logic                         ram0;
  logic                         ram1;
  logic                         left0;
  logic                         left1;

  // No new set while one is open or ready is still up
  assign acc = pre2core_done & ~active & ~dl1c_ready & (dport0.valid | dport1.valid);

  // Address decode on the peripheral bit
  assign arb_req0 = acc & dport0.valid & dport0.paddr[mcpu_pkg::periph_bit];
  assign arb_req1 = acc & dport1.valid & dport1.paddr[mcpu_pkg::periph_bit];
  assign ram0     = acc & dport0.valid & ~dport0.paddr[mcpu_pkg::periph_bit];
  assign ram1     = acc & dport1.valid & ~dport1.paddr[mcpu_pkg::periph_bit];

  assign idx0 = dport0.paddr[mcpu_pkg::dmem_aw-1:0];  // Upper bits alias
  assign idx1 = dport1.paddr[mcpu_pkg::dmem_aw-1:0];

  // Still waiting after this cycle's grant
  assign left0 = wait0 & ~arb_done0;
  assign left1 = wait1 & ~arb_done1;

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      init_idx      <= '0;
      pre2core_done <= 1'b0;
      active        <= 1'b0;
      wait0         <= 1'b0;
      wait1         <= 1'b0;
      dl1c_ready    <= 1'b0;
    end else begin
      if (!pre2core_done) begin
        init_idx <= init_idx + 1'b1;
        if (init_idx == mcpu_pkg::dmem_aw'(mcpu_pkg::dmem_words - 1))
          pre2core_done <= 1'b1;  // Last word cleared
      end
      if (acc) begin
        wait0      <= arb_req0;
        wait1      <= arb_req1;
        active     <= arb_req0 | arb_req1;
        dl1c_ready <= ~(arb_req0 | arb_req1);  // RAM only, next cycle
      end else if (active) begin
        wait0      <= left0;
        wait1      <= left1;
        active     <= left0 | left1;
        dl1c_ready <= ~(left0 | left1);  // Last MMIO access done
      end else begin
        dl1c_ready <= 1'b0;  // One-cycle pulse
      end
    end
  end

  // RAM and read capture
  always_ff @(posedge clkrst_core_clk) begin
    if (!pre2core_done)
      ram[init_idx] <= '0;
    if (ram0) begin
      rdata0_q <= ram[idx0];  // Old data on same-word write
      for (int b = 0; b < mcpu_pkg::be_w; b++)
        if (dport0.write[b])
          ram[idx0][8*b +: 8] <= dport0.wdata[8*b +: 8];
    end
    if (ram1) begin
      rdata1_q <= ram[idx1];
      for (int b = 0; b < mcpu_pkg::be_w; b++)
        if (dport1.write[b])
          ram[idx1][8*b +: 8] <= dport1.wdata[8*b +: 8];  // Port 1 wins
    end
    if (arb_done0)
      rdata0_q <= arb_rdata;
    if (arb_done1)
      rdata1_q <= arb_rdata;
  end

  assign dport0.rdata = rdata0_q;
  assign dport1.rdata = rdata1_q;

  // Core must never be released before the RAM is cleared
  a_ready_after_init: assert property (
    @(posedge clkrst_core_clk) disable iff (!arst_n)
    dl1c_ready |-> pre2core_done
  );

endmodule

// ==== mem/mcpu_periph_arb.sv ====
`timescale 1ns/1ns

module mcpu_periph_arb (
  input  logic                        clkrst_core_clk,
  input  logic                        arst_n,
  input  logic                        req0,
  input  logic                        req1,
  mcpu_dport_if.mem                   dport0,
  mcpu_dport_if.mem                   dport1,
  mcpu_periph_if.master               bus,
  output logic                        done0,
  output logic                        done1,
  output logic [mcpu_pkg::data_w-1:0] rdata
);

  logic                      q0;    // Port 0 access queued
  logic                      q1;
  logic                      gnt0;
  logic                      gnt1;
  logic                      gnt;
  logic [mcpu_pkg::be_w-1:0] be;

  // Fixed priority, port 0 first
  assign gnt0 = q0;
  assign gnt1 = q1 & ~q0;
  assign gnt  = gnt0 | gnt1;

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      q0 <= 1'b0;
      q1 <= 1'b0;
    end else begin
      q0 <= req0;                 // Granted in the next cycle
      q1 <= req1 | (q1 & ~gnt1);  // Waits one cycle behind port 0
    end
  end

  // Fields stay valid on the port until ready
  assign be        = gnt0 ? dport0.write : dport1.write;
  assign bus.re    = gnt & ~|be;                  // No enables means read
  assign bus.we    = gnt ? be : '0;
  assign bus.addr  = gnt0 ? dport0.paddr[mcpu_pkg::mmio_aw-1:0]
                          : dport1.paddr[mcpu_pkg::mmio_aw-1:0];
  assign bus.wdata = gnt0 ? dport0.wdata : dport1.wdata;

  // Done pulses in the access cycle while mem samples rdata
  assign done0 = gnt0;
  assign done1 = gnt1;
  assign rdata = bus.rdata;

  a_one_done: assert property (
    @(posedge clkrst_core_clk) disable iff (!arst_n)
    !(done0 && done1)
  );

  // Core keeps the request up while it is queued here
  a_valid_held: assert property (
    @(posedge clkrst_core_clk) disable iff (!arst_n)
    (!q0 || dport0.valid) && (!q1 || dport1.valid)
  );

endmodule

// ==== mmio/mcpu_soc_mmio.sv ====
`timescale 1ns/1ns

module mcpu_soc_mmio (
  input  logic                               clkrst_core_clk,
  input  logic                               arst_n,
  mcpu_periph_if.slave                       bus,
  input  logic [mcpu_pkg::data_w-1:0]        meminput,
  output logic [mcpu_pkg::data_w-1:0]        memoutput,
  output logic                               uart_tx,
  output logic [mcpu_pkg::uart_status_w-1:0] uart_status
);

  logic sel_out;     // memoutput addressed
  logic sel_udata;
  logic sel_ustat;
  logic uart_start;
  logic uart_busy;
  logic overrun;     // Sticky, dropped byte

  assign sel_out   = bus.addr == mcpu_pkg::mmio_aw'(mcpu_pkg::mmio_memoutput);
  assign sel_udata = bus.addr == mcpu_pkg::mmio_aw'(mcpu_pkg::mmio_uart_data);
  assign sel_ustat = bus.addr == mcpu_pkg::mmio_aw'(mcpu_pkg::mmio_uart_status);

  // Any byte write to the data offset sends the low byte
  assign uart_start = sel_udata & |bus.we;

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      memoutput <= '0;
      overrun   <= 1'b0;
    end else begin
      if (sel_out)
        for (int b = 0; b < mcpu_pkg::be_w; b++)
          if (bus.we[b])
            memoutput[8*b +: 8] <= bus.wdata[8*b +: 8];
      if (uart_start && uart_busy)
        overrun <= 1'b1;   // Frame in flight, byte lost
      else if (bus.re && sel_ustat)
        overrun <= 1'b0;   // Cleared by status read
    end
  end

  assign uart_status = {overrun, uart_busy};

  // Read mux, comb from offset
  always_comb begin
    case (bus.addr)
      mcpu_pkg::mmio_aw'(mcpu_pkg::mmio_memoutput):   bus.rdata = memoutput;
      mcpu_pkg::mmio_aw'(mcpu_pkg::mmio_meminput):    bus.rdata = meminput;
      mcpu_pkg::mmio_aw'(mcpu_pkg::mmio_uart_status):
        bus.rdata = mcpu_pkg::data_w'(uart_status);
      default:                                        bus.rdata = '0;  // Data is WO
    endcase
  end

  mcpu_uart_tx u_uart_tx (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .start           (uart_start),
    .data            (bus.wdata[7:0]),
    .tx              (uart_tx),
    .busy            (uart_busy)
  );

endmodule

// ==== mmio/mcpu_uart_tx.sv ====
`timescale 1ns/1ns

module mcpu_uart_tx (
  input  logic       clkrst_core_clk,
  input  logic       arst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       tx,
  output logic       busy
);

  localparam int div_w = $clog2(mcpu_pkg::uart_div);
  localparam int bit_w = $clog2(mcpu_pkg::uart_frame_bits);

  logic [div_w-1:0] div_cnt;   // Clocks within current bit
  logic [bit_w-1:0] bit_cnt;   // Bit index in frame, 0 is start
  logic [7:0]       shreg;     // Data bits, LSB first
  logic             bit_end;

  assign bit_end = div_cnt == div_w'(mcpu_pkg::uart_div - 1);

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx      <= 1'b1;   // Line idles high
      busy    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '1;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        tx      <= 1'b0;   // Start bit
        shreg   <= data;
        div_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (bit_end) begin
      div_cnt <= '0;
      if (bit_cnt == bit_w'(mcpu_pkg::uart_frame_bits - 1)) begin
        busy <= 1'b0;      // Stop bit finished
        tx   <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shreg[0];
        shreg   <= {1'b1, shreg[7:1]};  // Back-fill with stop level
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Line only leaves idle inside a frame
  a_idle_high: assert property (
    @(posedge clkrst_core_clk) disable iff (!arst_n)
    !busy |-> tx
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_mcpu_soc -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_mcpu_soc 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// ==== src.f ====
common/mcpu_pkg.sv
common/mcpu_periph_if.sv
common/mcpu_dport_if.sv
mmio/mcpu_uart_tx.sv
mmio/mcpu_soc_mmio.sv
mem/mcpu_periph_arb.sv
mem/mcpu_mem.sv
design/mcpu_soc_top.sv
tests/tb_mcpu_soc.sv

// ==== tests/tb_mcpu_soc.sv ====
`timescale 1ns/1ns

module tb_mcpu_soc;

  localparam int clk_period   = 8;
  localparam int frame_cycles = mcpu_pkg::uart_div * mcpu_pkg::uart_frame_bits;
  localparam int uart_frames  = 2;    // One sent, one dropped
  localparam int row_budget   = 40;   // Cycles per table row
  localparam logic [mcpu_pkg::paddr_w-1:0] pbase = mcpu_pkg::paddr_w'(1) << mcpu_pkg::periph_bit;

  typedef struct packed {
    logic [1:0]                        v;     // Port valid
    logic [1:0][mcpu_pkg::paddr_w-1:0] a;
    logic [1:0][mcpu_pkg::be_w-1:0]    be;    // Zero is a read
    logic [1:0][mcpu_pkg::data_w-1:0]  d;
    logic [1:0][mcpu_pkg::data_w-1:0]  e;     // Expected read data
    logic [1:0]                        c;     // Compare read data
    logic [3:0]                        lat;   // Cycles to dl1c_ready
    logic                              idle;  // Wait for UART idle first
    logic [mcpu_pkg::data_w-1:0]       min;   // meminput pin value
    logic [mcpu_pkg::data_w-1:0]       mo;    // memoutput after the row
    logic [mcpu_pkg::uart_status_w-1:0] st;   // uart_status after the row
  } row_t;

  logic                               clk;
  logic                               arst_n;
  logic [1:0]                         valid;
  logic [mcpu_pkg::paddr_w-1:0]       paddr [2];
  logic [mcpu_pkg::be_w-1:0]          byte_en [2];
  logic [mcpu_pkg::data_w-1:0]        data_out [2];
  logic [mcpu_pkg::data_w-1:0]        data_in [2];
  logic                               dl1c_ready;
  logic                               pre2core_done;
  logic [mcpu_pkg::data_w-1:0]        meminput;
  logic [mcpu_pkg::data_w-1:0]        memoutput;
  logic                               uart_tx;
  logic [mcpu_pkg::uart_status_w-1:0] uart_status;

  row_t                               rows [$];
  int                                 n_rows;
  logic [7:0]                         rx_bytes [$];  // Decoded UART bytes
  logic [7:0]                         bmodel [mcpu_pkg::dmem_words][mcpu_pkg::be_w];
  logic [31:0]                        lcg_state;
  logic [mcpu_pkg::data_w-1:0]        cur_min;
  logic [mcpu_pkg::data_w-1:0]        cur_mo;
  logic                               cur_busy;      // Modeled frame in flight
  logic                               cur_ovr;       // Modeled sticky overrun

  mcpu_soc_top UUT (
    .clkrst_core_clk  (clk),
    .arst_n           (arst_n),
    .mem2dc_valid0    (valid[0]),
    .mem2dc_paddr0    (paddr[0]),
    .mem2dc_write0    (byte_en[0]),
    .mem2dc_data_out0 (data_out[0]),
    .mem2dc_data_in0  (data_in[0]),
    .mem2dc_valid1    (valid[1]),
    .mem2dc_paddr1    (paddr[1]),
    .mem2dc_write1    (byte_en[1]),
    .mem2dc_data_out1 (data_out[1]),
    .mem2dc_data_in1  (data_in[1]),
    .dl1c_ready       (dl1c_ready),
    .pre2core_done    (pre2core_done),
    .meminput         (meminput),
    .memoutput        (memoutput),
    .uart_tx          (uart_tx),
    .uart_status      (uart_status)
  );

  task automatic end_in_failure();
    $display("Errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic wrong_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL %s got 0x%08h expected 0x%08h", sig, got, exp);
    end_in_failure();
  endtask

  task automatic broken_rule(input string msg);
    $display("%s", msg);
    end_in_failure();
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // RAM-only set with LCG data and expected words from the byte model
  task automatic ram_row(input bit v0, input int w0, input logic [mcpu_pkg::be_w-1:0] be0,
                         input bit v1, input int w1, input logic [mcpu_pkg::be_w-1:0] be1);
    row_t r;
    r      = '0;
    r.v    = {v1, v0};
    r.a[0] = mcpu_pkg::paddr_w'(w0);
    r.a[1] = mcpu_pkg::paddr_w'(w1);
    r.be   = {be1, be0};
    for (int p = 0; p < 2; p++) begin
      r.d[p] = next_rand();
      r.c[p] = r.v[p] && r.be[p] == '0;
      for (int b = 0; b < mcpu_pkg::be_w; b++)
        r.e[p][8*b +: 8] = bmodel[r.a[p][mcpu_pkg::dmem_aw-1:0]][b];  // Word before the set
    end
    for (int p = 0; p < 2; p++)  // Port 1 last so it wins on overlap
      for (int b = 0; b < mcpu_pkg::be_w; b++)
        if (r.v[p] && r.be[p][b])
          bmodel[r.a[p][mcpu_pkg::dmem_aw-1:0]][b] = r.d[p][8*b +: 8];
    r.lat = 4'd1;
    r.min = cur_min;
    r.mo  = cur_mo;
    r.st  = {cur_ovr, cur_busy};
    rows.push_back(r);
  endtask

  // MMIO-only set with literal expected read data
  task automatic mmio_row(input bit v0, input int o0, input logic [mcpu_pkg::be_w-1:0] be0,
                          input logic [31:0] d0, input logic [31:0] e0,
                          input bit v1, input int o1, input logic [mcpu_pkg::be_w-1:0] be1,
                          input logic [31:0] d1, input logic [31:0] e1, input bit idle);
    row_t r;
    r      = '0;
    r.v    = {v1, v0};
    r.a[0] = pbase | mcpu_pkg::paddr_w'(o0);
    r.a[1] = pbase | mcpu_pkg::paddr_w'(o1);
    r.be   = {be1, be0};
    r.d    = {d1, d0};
    r.e    = {e1, e0};
    r.c    = {v1 && be1 == '0, v0 && be0 == '0};
    r.lat  = 4'(1 + int'(v0) + int'(v1));  // One extra cycle per access
    r.idle = idle;
    for (int p = 0; p < 2; p++)  // Served in port order
      for (int b = 0; b < mcpu_pkg::be_w; b++)
        if (r.v[p] && r.be[p][b] && r.a[p][mcpu_pkg::mmio_aw-1:0] == mcpu_pkg::mmio_memoutput)
          cur_mo[8*b +: 8] = r.d[p][8*b +: 8];
    if (idle)
      cur_busy = 1'b0;  // Row starts once the frame is over
    for (int p = 0; p < 2; p++)
      if (r.v[p] && r.be[p] != '0 &&
          r.a[p][mcpu_pkg::mmio_aw-1:0] == mcpu_pkg::mmio_uart_data) begin
        if (cur_busy)
          cur_ovr = 1'b1;  // Byte dropped during a frame
        else
          cur_busy = 1'b1;
      end else if (r.v[p] && r.be[p] == '0 &&
                   r.a[p][mcpu_pkg::mmio_aw-1:0] == mcpu_pkg::mmio_uart_status) begin
        cur_ovr = 1'b0;
      end
    r.min = cur_min;
    r.mo  = cur_mo;
    r.st  = {cur_ovr, cur_busy};
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    lcg_state = 32'd13;
    cur_min   = 32'h5A5A_0F0F;
    cur_mo    = '0;
    cur_busy  = 1'b0;
    cur_ovr   = 1'b0;
    foreach (bmodel[w, b])
      bmodel[w][b] = 8'h00;  // RAM comes up cleared
    for (int w = 0; w < mcpu_pkg::dmem_words; w += 2)
      ram_row(1'b1, w, 4'h0, 1'b1, w + 1, 4'h0);
    for (int i = 0; i < 24; i++) begin  // Partial writes over 16 words
      rnd = next_rand();
      ram_row(1'b1, int'(rnd[19:16]), rnd[27:24], 1'b1, int'(rnd[23:20]), rnd[31:28]);
    end
    for (int w = 0; w < 16; w += 2)
      ram_row(1'b1, w, 4'h0, 1'b1, w + 1, 4'h0);
    ram_row(1'b1, 40, 4'b0111, 1'b1, 40, 4'b1110);  // Overlap on bytes 1 and 2
    ram_row(1'b1, 40, 4'h0, 1'b1, 40, 4'b0001);
    ram_row(1'b1, 40, 4'h0, 1'b0, 0, 4'h0);
    cur_min = 32'h1234_5678;
    mmio_row(1'b1, 0, 4'hF, 32'hA1B2_C3D4, 0, 1'b1, 1, 4'h0, 0, 32'h1234_5678, 1'b0);
    mmio_row(1'b1, 0, 4'b0101, 32'h1122_3344, 0, 1'b1, 0, 4'b1000, 32'h9900_0000, 0, 1'b0);
    cur_min = 32'hCAFE_0001;
    mmio_row(1'b1, 0, 4'h0, 0, 32'h9922_C344, 1'b1, 1, 4'h0, 0, 32'hCAFE_0001, 1'b0);
    mmio_row(1'b1, 2, 4'h1, 32'h0000_00A5, 0, 1'b0, 0, 4'h0, 0, 0, 1'b0);  // Frame starts
    mmio_row(1'b1, 3, 4'h0, 0, 32'h1, 1'b0, 0, 4'h0, 0, 0, 1'b0);          // Busy
    mmio_row(1'b0, 0, 4'h0, 0, 0, 1'b1, 2, 4'h1, 32'h0000_003C, 0, 1'b0);  // Dropped byte
    mmio_row(1'b1, 3, 4'h0, 0, 32'h3, 1'b1, 3, 4'h0, 0, 32'h1, 1'b0);      // Read clears overrun
    mmio_row(1'b1, 3, 4'h0, 0, 32'h0, 1'b0, 0, 4'h0, 0, 0, 1'b1);          // After the frame
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin : watchdog
    wait (n_rows > 0);
    repeat (n_rows * row_budget + mcpu_pkg::dmem_words + uart_frames * frame_cycles + 16)
      @(posedge clk);
    $display("Simulation timed out before all rows completed");
    end_in_failure();
  end

  // Finds the start bit on a low line and samples each bit mid-way
  initial begin : uart_monitor
    logic [7:0] rx_byte;
    wait (arst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        repeat (mcpu_pkg::uart_div / 2) @(negedge clk);
        assert (uart_tx === 1'b0) else broken_rule("UART start bit too short");
        for (int i = 0; i < 8; i++) begin
          repeat (mcpu_pkg::uart_div) @(negedge clk);
          rx_byte[i] = uart_tx;  // LSB first
          assert (uart_status[0] === 1'b1) else broken_rule("UART busy low inside a frame");
        end
        repeat (mcpu_pkg::uart_div) @(negedge clk);
        assert (uart_tx === 1'b1) else broken_rule("UART stop bit missing");
        rx_bytes.push_back(rx_byte);
      end
    end
  end

  initial begin : stimulus
    row_t r;
    int   cnt;
    int   lat;
    arst_n   <= 1'b0;
    valid    <= '0;
    meminput <= '0;
    for (int p = 0; p < 2; p++) begin
      paddr[p]    <= '0;
      byte_en[p]  <= '0;
      data_out[p] <= '0;
    end
    build_table();
    n_rows = rows.size();
    repeat (4) @(posedge clk);
    arst_n      <= 1'b1;
    valid[0]    <= 1'b1;  // Early write that the clear must ignore
    paddr[0]    <= mcpu_pkg::paddr_w'(5);
    byte_en[0]  <= 4'hF;
    data_out[0] <= 32'hDEAD_BEEF;
    @(negedge clk);
    assert (dl1c_ready === 1'b0 && pre2core_done === 1'b0 && uart_tx === 1'b1 &&
            memoutput === '0)
      else broken_rule("Outputs not in their reset state after reset release");
    cnt = 0;
    while (pre2core_done !== 1'b1) begin
      assert (cnt <= mcpu_pkg::dmem_words) else broken_rule("pre2core_done never rose");
      @(posedge clk);
      cnt++;
      if (cnt == 200)
        valid[0] <= 1'b0;
      @(negedge clk);
      assert (dl1c_ready === 1'b0) else broken_rule("dl1c_ready high during RAM clear");
    end
    assert (cnt == mcpu_pkg::dmem_words)
      else wrong_value("pre2core_done cycles", 32'(cnt), 32'(mcpu_pkg::dmem_words));
    foreach (rows[i]) begin
      r   = rows[i];
      cnt = 0;
      while (r.idle && uart_status[0] !== 1'b0) begin
        assert (cnt < frame_cycles) else broken_rule("UART stays busy after the frame");
        @(negedge clk);
        cnt++;
      end
      @(posedge clk);
      meminput <= r.min;
      for (int p = 0; p < 2; p++) begin
        valid[p]    <= r.v[p];
        paddr[p]    <= r.a[p];
        byte_en[p]  <= r.be[p];
        data_out[p] <= r.d[p];
      end
      lat = 0;
      @(negedge clk);
      while (dl1c_ready !== 1'b1) begin
        assert (lat < row_budget) else broken_rule($sformatf("No dl1c_ready for row %0d", i));
        @(posedge clk);
        lat++;
        @(negedge clk);
      end
      assert (lat == int'(r.lat)) else wrong_value("dl1c_ready latency", 32'(lat), 32'(r.lat));
      for (int p = 0; p < 2; p++)
        if (r.c[p])
          assert (data_in[p] === r.e[p])
            else wrong_value($sformatf("mem2dc_data_in%0d", p), data_in[p], r.e[p]);
      @(posedge clk);
      valid <= '0;  // Dropped the cycle after ready
      @(negedge clk);
      assert (dl1c_ready === 1'b0) else broken_rule("dl1c_ready high for more than one cycle");
      assert (memoutput === r.mo) else wrong_value("memoutput", memoutput, r.mo);
      assert (uart_status === r.st)
        else wrong_value("uart_status", 32'(uart_status), 32'(r.st));
    end
    assert (rx_bytes.size() == 1)
      else broken_rule($sformatf("UART sent %0d bytes instead of one", rx_bytes.size()));
    assert (rx_bytes[0] === 8'hA5) else wrong_value("uart_tx byte", 32'(rx_bytes[0]), 32'hA5);
    $display("No errors");
    $finish;
  end

endmodule
